//--- src/sramCfgPkg.sv
// Geometry of the tiled on-chip memory
// Sets the full array and the block-RAM tile it is built from, and how tiles
// are split into columns across the width and rows across the depth

`default_nettype none

package sramCfgPkg;

  // Full memory
  localparam int unsigned NumWords  = 2048;
  localparam int unsigned DataWidth = 96;
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned BeWidth   = (DataWidth + ByteWidth - 1) / ByteWidth;  // 12
  localparam int unsigned AddrWidth = $clog2(NumWords);                         // 11

  // One block-RAM tile
  localparam int unsigned TileWidth     = 64;
  localparam int unsigned TileWords     = 512;
  localparam int unsigned TileAddrWidth = $clog2(TileWords);     // 9
  localparam int unsigned TileBeWidth   = TileWidth / ByteWidth; // 8

  // Depth split into rows, upper address bits pick the row
  localparam int unsigned NumRows     = NumWords / TileWords; // 4
  localparam int unsigned RowSelWidth = $clog2(NumRows);      // 2

  // Width split into columns, last one may be narrower
  localparam int unsigned NumColumns = (DataWidth + TileWidth - 1) / TileWidth; // 2

endpackage

`default_nettype wire

//--- src/sramTypesPkg.sv
// Types for the tiled memory
// Operation code, word and tile-level data, address and byte-enable types,
// and the request bundle seen at the memory port

`default_nettype none

package sramTypesPkg;

  import sramCfgPkg::*;

  // Replaces a plain write-enable bit
  typedef enum logic {
    OpRead  = 1'b0,
    OpWrite = 1'b1
  } memOp_e;

  // Full memory word
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [BeWidth-1:0]   be_t;

  // Single tile
  typedef logic [TileAddrWidth-1:0] tileAddr_t;
  typedef logic [TileWidth-1:0]     tileData_t;
  typedef logic [TileBeWidth-1:0]   tileBe_t;

  // 120 bits in all
  typedef struct packed {
    memOp_e op;
    addr_t  addr;
    data_t  wdata;  // Only meaningful for writes
    be_t    be;
  } sramReq_t;

endpackage

`default_nettype wire

//--- src/bramTile.sv
// Behavioral block-RAM tile, 64 bits by 512 words
// Byte-enable write port and a registered read port, contents start at zero

`default_nettype none

module bramTile import sramCfgPkg::*, sramTypesPkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      readEn_i,
  input  logic      writeEn_i,
  input  tileAddr_t addr_i,
  input  tileData_t wdata_i,
  input  tileBe_t   be_i,
  output tileData_t rdata_o
);

  tileData_t mem [TileWords];
  tileData_t rdataQ;

  // Power-up contents
  initial begin
    for (int i = 0; i < TileWords; i++) begin
      mem[i] = '0;
    end
  end

  // Write port, one lane per enabled byte
  always_ff @(posedge clk_i) begin
    if (writeEn_i) begin
      for (int b = 0; b < TileBeWidth; b++) begin
        if (be_i[b]) begin
          mem[addr_i][b*ByteWidth +: ByteWidth] <= wdata_i[b*ByteWidth +: ByteWidth];
        end
      end
    end
  end

  // Read register holds until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdataQ <= '0;
    end else if (readEn_i) begin
      rdataQ <= mem[addr_i];
    end
  end

  assign rdata_o = rdataQ;

  // The column decode never asks a tile to read and write at once
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(readEn_i && writeEn_i))
    else $error("bramTile: read and write enable high together");

endmodule

`default_nettype wire

//--- src/bramColumn.sv
// One column of block-RAM tiles stacked in depth
// Decodes the row from the upper address bits, gates byte enables to the
// column width and picks the read data with a registered row select

`default_nettype none

module bramColumn import sramCfgPkg::*, sramTypesPkg::*; #(
  parameter int unsigned ColWidth = 64
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  memOp_e    op_i,
  input  addr_t     addr_i,
  input  tileData_t wdata_i,
  input  tileBe_t   be_i,
  output tileData_t rdata_o
);

  localparam int unsigned ColBytes  = ColWidth / ByteWidth;
  localparam tileBe_t     ColBeMask = tileBe_t'((1 << ColBytes) - 1);

  logic [RowSelWidth-1:0] rowSel;
  logic [RowSelWidth-1:0] rowSelQ;   // Row of the last read
  tileAddr_t              tileAddr;
  tileBe_t                tileBe;
  logic                   isRead;
  logic                   isWrite;
  logic [NumRows-1:0]     readEn;
  logic [NumRows-1:0]     writeEn;
  tileData_t [NumRows-1:0] tileRdata;

  assign rowSel   = addr_i[AddrWidth-1 -: RowSelWidth];
  assign tileAddr = addr_i[TileAddrWidth-1:0];

  assign isRead  = req_i && (op_i == OpRead);
  assign isWrite = req_i && (op_i == OpWrite);

  // Bytes past the column width never reach the tiles
  assign tileBe = isWrite ? (be_i & ColBeMask) : '0;

  // One-hot row enables
  always_comb begin
    readEn  = '0;
    writeEn = '0;
    for (int r = 0; r < NumRows; r++) begin
      if (rowSel == RowSelWidth'(r)) begin
        readEn[r]  = isRead;
        writeEn[r] = isWrite;
      end
    end
  end

  for (genvar r = 0; r < NumRows; r++) begin : gen_row
    bramTile tile_i (
      .clk_i     ( clk_i        ),
      .rst_ni    ( rst_ni       ),
      .readEn_i  ( readEn[r]    ),
      .writeEn_i ( writeEn[r]   ),
      .addr_i    ( tileAddr     ),
      .wdata_i   ( wdata_i      ),
      .be_i      ( tileBe       ),
      .rdata_o   ( tileRdata[r] )
    );
  end

  // Loads with the tile read register, so writes leave the output alone
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rowSelQ <= '0;
    end else if (isRead) begin
      rowSelQ <= rowSel;
    end
  end

  assign rdata_o = tileRdata[rowSelQ];

  // Only one tile of the column is touched per request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({readEn, writeEn}))
    else $error("bramColumn: more than one row enable high");

endmodule

`default_nettype wire

//--- src/tiledSram.sv
// Single-port byte-writable memory built from block-RAM tiles
// Slices each request across the tile columns and joins their read data,
// one request per cycle with a read latency of one cycle

`default_nettype none

module tiledSram import sramCfgPkg::*, sramTypesPkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_i,
  input  sramReq_t reqData_i,
  output data_t    rdata_o
);

  tileData_t [NumColumns-1:0] colWdata;
  tileBe_t   [NumColumns-1:0] colBe;
  tileData_t [NumColumns-1:0] colRdata;

  for (genvar c = 0; c < NumColumns; c++) begin : gen_col
    // Last column takes whatever width is left over
    localparam int unsigned ColWidth =
      ((c == NumColumns - 1) && ((DataWidth % TileWidth) != 0)) ?
      DataWidth % TileWidth : TileWidth;
    localparam int unsigned ColBytes = ColWidth / ByteWidth;

    // Zero-filled up to the tile width
    assign colWdata[c] = tileData_t'(reqData_i.wdata[c*TileWidth +: ColWidth]);
    assign colBe[c]    = tileBe_t'(reqData_i.be[c*TileBeWidth +: ColBytes]);

    bramColumn #(
      .ColWidth ( ColWidth )
    ) column_i (
      .clk_i   ( clk_i            ),
      .rst_ni  ( rst_ni           ),
      .req_i   ( req_i            ),
      .op_i    ( reqData_i.op     ),
      .addr_i  ( reqData_i.addr   ),
      .wdata_i ( colWdata[c]      ),
      .be_i    ( colBe[c]         ),
      .rdata_o ( colRdata[c]      )
    );

    assign rdata_o[c*TileWidth +: ColWidth] = colRdata[c][ColWidth-1:0];  // Drop the fill bits
  end

  // Every column must have answered a read in time
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && reqData_i.op == OpRead) |=> !$isunknown(rdata_o))
    else $error("tiledSram: unknown read data one cycle after a read");

endmodule

`default_nettype wire

//--- test/sramModel.svh
// Reference model of the tiled memory
// Full-word array with byte merge on writes and the word a read should return

`ifndef SRAM_MODEL_SVH
`define SRAM_MODEL_SVH

data_t modelMem [NumWords];
data_t expRdata;  // Last word read, held through writes and idle cycles

// Contents start at zero, as does the read data after reset
task automatic clearModel();
  for (int i = 0; i < NumWords; i++) begin
    modelMem[i] = '0;
  end
  expRdata = '0;
endtask

// Enabled bytes come from the new word, the rest stay
function automatic data_t mergeBytes(input data_t oldWord, input data_t newWord, input be_t be);
  data_t merged;
  merged = oldWord;
  for (int b = 0; b < BeWidth; b++) begin
    if (be[b]) begin
      merged[b*ByteWidth +: ByteWidth] = newWord[b*ByteWidth +: ByteWidth];
    end
  end
  return merged;
endfunction

// Called once the DUT has taken the request
task automatic applyRequest(input sramReq_t r);
  if (r.op == OpWrite) begin
    modelMem[r.addr] = mergeBytes(modelMem[r.addr], r.wdata, r.be);
  end else begin
    expRdata = modelMem[r.addr];
  end
endtask

`endif

//--- test/tbTiledSram.sv
// Testbench for the tiled memory
// Directed and random traffic against a byte-merge model, read data checked every cycle

`default_nettype none

module tbTiledSram import sramCfgPkg::*, sramTypesPkg::*; ();

  localparam int ResetCycles    = 8;
  localparam int NumRandom      = 3000;
  localparam int DirectedCycles = 200;  // Upper bound for the directed part
  localparam int MaxCycles      = 2 * (ResetCycles + DirectedCycles + NumRandom);

  logic     clk;
  logic     rstN;
  logic     req;
  sramReq_t reqData;
  data_t    rdata;

  int       seed = 83;
  int       cycleCount = 0;
  logic     prevStrobe;  // Request driven last cycle, taken by the DUT at the next edge
  sramReq_t prevReq;

  `include "sramModel.svh"

  tiledSram tiledSram_i (
    .clk_i     ( clk     ),
    .rst_ni    ( rstN    ),
    .req_i     ( req     ),
    .reqData_i ( reqData ),
    .rdata_o   ( rdata   )
  );

  always #4 clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic checkValue(input string name, input data_t actual, input data_t expected);
    if (actual !== expected) begin
      abortRun($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MaxCycles) begin
      abortRun($sformatf("Timeout: stimulus still running after %0d cycles", cycleCount));
    end
  end

  // One request per rising edge, read data checked at the falling edge
  task automatic runCycle(input logic strobe, input sramReq_t r);
    @(posedge clk);
    req     <= strobe;
    reqData <= r;
    if (prevStrobe) begin
      applyRequest(prevReq);  // DUT took it at this edge
    end
    prevStrobe = strobe;
    prevReq    = r;
    @(negedge clk);
    checkValue("rdata_o", rdata, expRdata);
  endtask

  task automatic writeWord(input addr_t a, input data_t d, input be_t be);
    sramReq_t r;
    r.op    = OpWrite;
    r.addr  = a;
    r.wdata = d;
    r.be    = be;
    runCycle(1'b1, r);
  endtask

  task automatic readWord(input addr_t a);
    sramReq_t r;
    r      = '0;
    r.op   = OpRead;
    r.addr = a;
    runCycle(1'b1, r);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) runCycle(1'b0, '0);
  endtask

  task automatic randomWord(output data_t d);
    d = {$random(seed), $random(seed), $random(seed)};
  endtask

  // Mostly a small window spanning all rows, so reads often hit written words
  task automatic randomRequest(output logic strobe, output sramReq_t r);
    strobe = ($random(seed) & 3) != 0;
    r.op   = ($random(seed) & 1) ? OpWrite : OpRead;
    r.addr = addr_t'($random(seed));
    if (($random(seed) & 7) != 0) begin
      r.addr = r.addr & 11'h60F;
    end
    randomWord(r.wdata);
    r.be = be_t'($random(seed));
  endtask

  function automatic addr_t rowAddr(input int row, input int offset);
    return addr_t'(row * TileWords + offset);
  endfunction

  initial begin
    data_t    d;
    logic     strobe;
    sramReq_t r;
    be_t      partialBe [4];

    partialBe[0] = 12'hA5C;
    partialBe[1] = 12'h0F0;
    partialBe[2] = 12'hF00;
    partialBe[3] = 12'h001;

    clk        = 1'b0;
    rstN       = 1'b0;
    req        = 1'b0;
    reqData    = '0;
    prevStrobe = 1'b0;
    prevReq    = '0;
    clearModel();

    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkValue("rdata_o", rdata, expRdata);

    // Never-written words in every row read as zero
    for (int row = 0; row < NumRows; row++) begin
      readWord(rowAddr(row, 37 * row + 5));
    end
    idleCycles(1);

    // Full words across both columns, back to back
    for (int row = 0; row < NumRows; row++) begin
      randomWord(d);
      writeWord(rowAddr(row, 100 * row + 3), d, '1);
    end
    for (int row = 0; row < NumRows; row++) begin
      readWord(rowAddr(row, 100 * row + 3));
    end

    // Partial byte enables over the same words
    for (int row = 0; row < NumRows; row++) begin
      randomWord(d);
      writeWord(rowAddr(row, 100 * row + 3), d, partialBe[row]);
      readWord(rowAddr(row, 100 * row + 3));
    end

    // Read data holds through idle cycles and writes, same address included
    readWord(rowAddr(2, 203));
    idleCycles(3);
    randomWord(d);
    writeWord(rowAddr(2, 203), d, '1);
    writeWord(rowAddr(1, 9), d, 12'h3C3);
    idleCycles(2);
    readWord(rowAddr(2, 203));
    idleCycles(2);

    for (int i = 0; i < NumRandom; i++) begin
      randomRequest(strobe, r);
      runCycle(strobe, r);
    end
    idleCycles(2);  // Flush the last request

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- tiledSram.f
+incdir+test
src/sramCfgPkg.sv
src/sramTypesPkg.sv
src/bramTile.sv
src/bramColumn.sv
src/tiledSram.sv
test/tbTiledSram.sv

//--- Makefile
# Verilator build and run for the tiled memory testbench

VERILATOR ?= verilator
TOP       ?= tbTiledSram
FILELIST  ?= tiledSram.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard test/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
